//--- logic/mipsAluPkg.sv
package mipsAluPkg;

    //////////////////////////////
    // ALU operation codes
    //////////////////////////////
    typedef enum logic [4:0] {
        ADD   = 5'b00000,
        ADDU  = 5'b00001,
        SUB   = 5'b00010,
        MULT  = 5'b00011,  // HI:LO only
        MULTU = 5'b00100,  // HI:LO only
        AND   = 5'b00101,
        OR    = 5'b00110,
        NOR   = 5'b00111,
        XOR   = 5'b01000,
        SLL   = 5'b01001,
        SRL   = 5'b01010,
        SLLV  = 5'b01011,
        SLT   = 5'b01100,
        MOVN  = 5'b01101,
        MOVZ  = 5'b01110,
        SRLV  = 5'b01111,
        SRA   = 5'b10000,
        SRAV  = 5'b10001,
        SLTU  = 5'b10010,
        MUL   = 5'b10011,  // Low word of signed product
        MADD  = 5'b10100,
        MSUB  = 5'b10101,
        SEB   = 5'b10110,
        SEH   = 5'b10111,
        MFHI  = 5'b11000,
        MFLO  = 5'b11001,
        NOP   = 5'b11111   // Undefined encodings land here
    } aluOp;

    //////////////////////////////
    // Instruction encodings
    //////////////////////////////
    localparam logic [5:0] OP_SPECIAL  = 6'h00;  // R-type group
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;  // mul, madd, msub
    localparam logic [5:0] OP_SPECIAL3 = 6'h1f;  // bshfl group

    // SPECIAL function field
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_SLLV  = 6'h04;
    localparam logic [5:0] FN_SRLV  = 6'h06;
    localparam logic [5:0] FN_SRAV  = 6'h07;
    localparam logic [5:0] FN_MOVZ  = 6'h0a;
    localparam logic [5:0] FN_MOVN  = 6'h0b;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUB   = 6'h22;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_NOR   = 6'h27;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_SLTU  = 6'h2b;

    // SPECIAL2 function field
    localparam logic [5:0] FN_MADD  = 6'h00;
    localparam logic [5:0] FN_MUL   = 6'h02;
    localparam logic [5:0] FN_MSUB  = 6'h04;

    // SPECIAL3, shift field picks the variant
    localparam logic [5:0] FN_BSHFL = 6'h20;
    localparam logic [4:0] SA_SEB   = 5'h10;
    localparam logic [4:0] SA_SEH   = 5'h18;

    //////////////////////////////
    // Stage bundles
    //////////////////////////////
    typedef struct packed {
        logic [5:0]  opcode;
        logic [5:0]  funct;
        logic [4:0]  shamt;
        logic [31:0] rsValue;  // A operand
        logic [31:0] rtValue;  // B operand
    } instrFields;

    typedef struct packed {
        logic        regWrite;
        logic [31:0] result;
        logic        zero;     // Result is all zero
    } writebackBundle;

endpackage

//--- logic/aluControl.sv
`timescale 1ns/1ps

module aluControl (
    input  logic [5:0]       opcode,
    input  logic [5:0]       funct,
    input  logic [4:0]       shamt,
    output mipsAluPkg::aluOp op
);
    import mipsAluPkg::*;

    aluOp specialOp;   // R-type decode
    aluOp special2Op;  // Multiply-accumulate group
    aluOp special3Op;  // Sign-extend group

    //////////////////////////////
    // SPECIAL function decode
    //////////////////////////////
    always_comb begin
        case (funct)
            FN_SLL:   specialOp = SLL;
            FN_SRL:   specialOp = SRL;   // Rotate form not decoded
            FN_SRA:   specialOp = SRA;
            FN_SLLV:  specialOp = SLLV;
            FN_SRLV:  specialOp = SRLV;
            FN_SRAV:  specialOp = SRAV;
            FN_MOVZ:  specialOp = MOVZ;
            FN_MOVN:  specialOp = MOVN;
            FN_MFHI:  specialOp = MFHI;
            FN_MFLO:  specialOp = MFLO;
            FN_MULT:  specialOp = MULT;
            FN_MULTU: specialOp = MULTU;
            FN_ADD:   specialOp = ADD;   // No overflow trap
            FN_ADDU:  specialOp = ADDU;
            FN_SUB:   specialOp = SUB;
            FN_AND:   specialOp = AND;
            FN_OR:    specialOp = OR;
            FN_XOR:   specialOp = XOR;
            FN_NOR:   specialOp = NOR;
            FN_SLT:   specialOp = SLT;
            FN_SLTU:  specialOp = SLTU;
            default:  specialOp = NOP;
        endcase
    end

    //////////////////////////////
    // SPECIAL2 function decode
    //////////////////////////////
    always_comb begin
        case (funct)
            FN_MADD: special2Op = MADD;
            FN_MUL:  special2Op = MUL;
            FN_MSUB: special2Op = MSUB;
            default: special2Op = NOP;
        endcase
    end

    //////////////////////////////
    // SPECIAL3 bshfl decode
    //////////////////////////////
    always_comb begin
        special3Op = NOP;
        if (funct == FN_BSHFL) begin
            // Shift field selects byte or halfword
            case (shamt)
                SA_SEB:  special3Op = SEB;
                SA_SEH:  special3Op = SEH;
                default: special3Op = NOP;
            endcase
        end
    end

    // Opcode picks the group
    always_comb begin
        case (opcode)
            OP_SPECIAL:  op = specialOp;
            OP_SPECIAL2: op = special2Op;
            OP_SPECIAL3: op = special3Op;
            default:     op = NOP;  // Immediates and branches not handled here
        endcase
    end

endmodule

//--- logic/alu32Bit.sv
`timescale 1ns/1ps

module alu32Bit (
    input  mipsAluPkg::aluOp op,
    input  logic [31:0]      a,         // rs operand
    input  logic [31:0]      b,         // rt operand, shifted value
    input  logic [4:0]       shamt,
    input  logic [63:0]      hiLo,      // Current HI:LO
    output logic [31:0]      result,
    output logic             regWrite,
    output logic             hiLoEn,
    output logic [63:0]      hiLoNext
);
    import mipsAluPkg::*;

    logic [4:0]  shiftAmt;     // Immediate or variable amount
    logic [63:0] signedProd;   // a * b, two's complement
    logic [63:0] unsignedProd;

    //////////////////////////////
    // Shared datapath pieces
    //////////////////////////////

    // Variable shifts take the amount from rs
    always_comb begin
        case (op)
            SLLV, SRLV, SRAV: shiftAmt = a[4:0];
            default:          shiftAmt = shamt;
        endcase
    end

    // One multiplier each for signed and unsigned
    assign signedProd   = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    assign unsignedProd = {32'd0, a} * {32'd0, b};

    //////////////////////////////
    // Operation select
    //////////////////////////////
    always_comb begin
        result   = 32'd0;   // Quiet defaults
        regWrite = 1'b0;
        hiLoEn   = 1'b0;
        hiLoNext = hiLo;
        case (op)
            // Add and subtract wrap silently
            ADD, ADDU: begin
                result   = a + b;
                regWrite = 1'b1;
            end
            SUB: begin
                result   = a - b;
                regWrite = 1'b1;
            end

            // Bitwise logic
            AND: begin
                result   = a & b;
                regWrite = 1'b1;
            end
            OR: begin
                result   = a | b;
                regWrite = 1'b1;
            end
            NOR: begin
                result   = ~(a | b);
                regWrite = 1'b1;
            end
            XOR: begin
                result   = a ^ b;
                regWrite = 1'b1;
            end

            // Compares
            SLT: begin
                result   = {31'd0, $signed(a) < $signed(b)};
                regWrite = 1'b1;
            end
            SLTU: begin
                result   = {31'd0, a < b};
                regWrite = 1'b1;
            end

            // Shifts act on b
            SLL, SLLV: begin
                result   = b << shiftAmt;
                regWrite = 1'b1;
            end
            SRL, SRLV: begin
                result   = b >> shiftAmt;   // Zero fill
                regWrite = 1'b1;
            end
            SRA, SRAV: begin
                result   = $signed(b) >>> shiftAmt;  // Sign fill
                regWrite = 1'b1;
            end

            // Conditional moves, write only when condition holds
            MOVN: begin
                result   = a;
                regWrite = (b != 32'd0);
            end
            MOVZ: begin
                result   = a;
                regWrite = (b == 32'd0);
            end

            // Multiplies into HI:LO, no register write
            MULT: begin
                hiLoEn   = 1'b1;
                hiLoNext = signedProd;
            end
            MULTU: begin
                hiLoEn   = 1'b1;
                hiLoNext = unsignedProd;
            end
            MADD: begin
                hiLoEn   = 1'b1;
                hiLoNext = hiLo + signedProd;  // Accumulate
            end
            MSUB: begin
                hiLoEn   = 1'b1;
                hiLoNext = hiLo - signedProd;
            end
            MUL: begin
                result   = signedProd[31:0];   // HI:LO untouched
                regWrite = 1'b1;
            end

            // HI/LO reads
            MFHI: begin
                result   = hiLo[63:32];
                regWrite = 1'b1;
            end
            MFLO: begin
                result   = hiLo[31:0];
                regWrite = 1'b1;
            end

            // Sign extension of rt
            SEB: begin
                result   = {{24{b[7]}}, b[7:0]};
                regWrite = 1'b1;
            end
            SEH: begin
                result   = {{16{b[15]}}, b[15:0]};
                regWrite = 1'b1;
            end

            // NOP and anything unlisted keep the defaults
            default: begin
                result   = 32'd0;
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/executeRegisters.sv
`timescale 1ns/1ps

module executeRegisters (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue,     // One-cycle strobe
    input  logic [31:0]                result,
    input  logic                       regWrite,
    input  logic                       hiLoEn,
    input  logic [63:0]                hiLoNext,
    output logic [63:0]                hiLo,      // Architectural HI:LO
    output logic                       done,
    output mipsAluPkg::writebackBundle wb
);

    logic [31:0] hiReg;
    logic [31:0] loReg;
    logic        resultZero;

    //////////////////////////////
    // HI/LO pair
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            hiReg <= 32'd0;
            loReg <= 32'd0;
        end else if (issue && hiLoEn) begin
            hiReg <= hiLoNext[63:32];
            loReg <= hiLoNext[31:0];
        end
    end

    assign hiLo = {hiReg, loReg};  // Seen by the next issue

    //////////////////////////////
    // Writeback and done
    //////////////////////////////
    assign resultZero = (result == 32'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb <= '0;
        end else if (issue) begin
            wb.regWrite <= regWrite;
            wb.result   <= result;
            wb.zero     <= resultZero;
        end
    end

    // Done follows every issue by one clock
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= issue;
        end
    end

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue,
    input  mipsAluPkg::instrFields     instr,
    output logic                       done,
    output mipsAluPkg::writebackBundle wb
);
    import mipsAluPkg::*;

    aluOp        op;          // Decoded operation
    logic [31:0] result;
    logic        regWrite;
    logic        hiLoEn;
    logic [63:0] hiLoNext;
    logic [63:0] hiLo;        // Registered HI:LO fed back

    //////////////////////////////
    // Decode
    //////////////////////////////
    aluControl uAluControl (
        .opcode (instr.opcode),
        .funct  (instr.funct),
        .shamt  (instr.shamt),
        .op     (op)
    );

    //////////////////////////////
    // Compute
    //////////////////////////////
    alu32Bit uAlu (
        .op       (op),
        .a        (instr.rsValue),
        .b        (instr.rtValue),
        .shamt    (instr.shamt),
        .hiLo     (hiLo),
        .result   (result),
        .regWrite (regWrite),
        .hiLoEn   (hiLoEn),
        .hiLoNext (hiLoNext)
    );

    // State and writeback register
    executeRegisters uRegs (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .result   (result),
        .regWrite (regWrite),
        .hiLoEn   (hiLoEn),
        .hiLoNext (hiLoNext),
        .hiLo     (hiLo),
        .done     (done),
        .wb       (wb)
    );

endmodule

//--- test/executeStage_chk.sv
`timescale 1ns/1ps

module executeStage_chk (
    input logic                       clk,
    input logic                       reset,
    input logic                       issue,
    input logic                       done,
    input mipsAluPkg::writebackBundle wb
);

    //////////////////////////////
    // Issue and done handshake
    //////////////////////////////
    doneAfterIssue: assert property (@(posedge clk) disable iff (reset) issue |=> done)
        else $error("done did not follow issue by one cycle");

    // No spurious strobe
    doneOnlyAfterIssue: assert property (@(posedge clk) disable iff (reset) !issue |=> !done)
        else $error("done rose without an issue the cycle before");

    doneLowInReset: assert property (@(posedge clk) reset |=> !done)
        else $error("done high while reset held");

    //////////////////////////////
    // Writeback flags
    //////////////////////////////
    zeroFlagMatches: assert property (@(posedge clk) disable iff (reset)
                                      done |-> (wb.zero == (wb.result == 32'd0)))
        else $error("wb.zero disagrees with wb.result");

endmodule

//--- test/executeStageTb.sv
`timescale 1ns/1ps

module executeStageTb;
    import mipsAluPkg::*;

    localparam int doneTimeout = 10;  // Cycles allowed for done

    logic           clk = 1'b0;
    logic           reset;
    logic           issue;
    instrFields     instr;
    logic           done;
    writebackBundle wb;

    integer      seed = 23193;
    int          checkCount = 0;
    int          errorCount = 0;
    logic [63:0] modelHiLo;  // Reference HI:LO

    executeStage DUT (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .instr (instr),
        .done  (done),
        .wb    (wb)
    );

    bind executeStage executeStage_chk uChk (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .done  (done),
        .wb    (wb)
    );

    always #20 clk = ~clk;  // 40 ns period

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic instrFields encode(input logic [5:0] opcode, input logic [5:0] funct,
                                          input logic [4:0] shamt, input logic [31:0] rs,
                                          input logic [31:0] rt);
        return {opcode, funct, shamt, rs, rt};
    endfunction

    function automatic instrFields special(input logic [5:0] funct, input logic [4:0] shamt,
                                           input logic [31:0] rs, input logic [31:0] rt);
        return encode(OP_SPECIAL, funct, shamt, rs, rt);
    endfunction

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    // Issue one instruction, wait for done, check the writeback
    task automatic execute(input instrFields f, input logic expWrite, input logic checkResult,
                           input logic [31:0] expResult, input string name);
        int waitCycles;
        issue = 1'b1;
        instr = f;
        @(posedge clk);
        #2;
        issue = 1'b0;
        instr = '0;
        waitCycles = 0;
        while (!done && waitCycles < doneTimeout) begin
            @(posedge clk);
            #2;
            waitCycles++;
        end
        checkCount++;
        if (!done) begin
            $display("Timed out waiting for done after issuing %s", name);
            errorCount++;
        end else begin
            assert (wb.regWrite == expWrite) else begin
                $display("Error at %0t: %s regWrite %0b, expected %0b",
                         $time, name, wb.regWrite, expWrite);
                errorCount++;
            end
            if (checkResult) begin
                assert (wb.result == expResult && wb.zero == (expResult == 32'd0)) else begin
                    $display("Error at %0t: %s result %h zero %0b, expected %h",
                             $time, name, wb.result, wb.zero, expResult);
                    errorCount++;
                end
            end
        end
    endtask

    task automatic readHiLo(input string name);
        execute(special(FN_MFHI, 5'd0, 32'd0, 32'd0), 1'b1, 1'b1, modelHiLo[63:32], name);
        execute(special(FN_MFLO, 5'd0, 32'd0, 32'd0), 1'b1, 1'b1, modelHiLo[31:0], name);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic resetTest();
        checkCount++;
        assert (done == 1'b0 && wb == '0) else begin
            $display("Error at %0t: done or wb not clear after reset", $time);
            errorCount++;
        end
        readHiLo("hilo after reset");
    endtask

    task automatic arithLogicTest();
        logic [31:0] edgeA [4] = '{32'h0, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};
        logic [31:0] edgeB [4] = '{32'h0, 32'h1, 32'h1, 32'h7fff_ffff};
        logic [31:0] a;
        logic [31:0] b;
        logic        lessSigned;
        for (int i = 0; i < 10; i++) begin
            if (i < 4) begin
                a = edgeA[i];
                b = edgeB[i];
            end else begin
                a = randWord();
                b = randWord();
            end
            lessSigned = (a[31] != b[31]) ? a[31] : (a < b);  // Sign bits decide first
            execute(special(FN_ADD, 5'd0, a, b), 1'b1, 1'b1, a + b, "add");
            execute(special(FN_ADDU, 5'd0, a, b), 1'b1, 1'b1, a + b, "addu");
            execute(special(FN_SUB, 5'd0, a, b), 1'b1, 1'b1, a + ~b + 32'd1, "sub");
            execute(special(FN_AND, 5'd0, a, b), 1'b1, 1'b1, a & b, "and");
            execute(special(FN_OR, 5'd0, a, b), 1'b1, 1'b1, a | b, "or");
            execute(special(FN_NOR, 5'd0, a, b), 1'b1, 1'b1, ~a & ~b, "nor");
            execute(special(FN_XOR, 5'd0, a, b), 1'b1, 1'b1, a ^ b, "xor");
            execute(special(FN_SLT, 5'd0, a, b), 1'b1, 1'b1, {31'd0, lessSigned}, "slt");
            execute(special(FN_SLTU, 5'd0, a, b), 1'b1, 1'b1, {31'd0, a < b}, "sltu");
        end
    endtask

    task automatic shiftTest();
        logic [31:0] b;
        logic [31:0] rs;
        logic [31:0] fill;
        logic [4:0]  s;
        for (int i = 0; i < 6; i++) begin
            b  = randWord();
            rs = randWord();
            if (i % 2 == 0) b[31] = 1'b1;  // Negative value for sign fill
            if (i == 1) rs[4:0] = 5'd31;
            if (i == 2) rs[4:0] = 5'd0;
            s    = rs[4:0];
            fill = b[31] ? ~(32'hffff_ffff >> s) : 32'd0;
            execute(special(FN_SLL, s, 32'd0, b), 1'b1, 1'b1, b << s, "sll");
            execute(special(FN_SRL, s, 32'd0, b), 1'b1, 1'b1, b >> s, "srl");
            execute(special(FN_SRA, s, 32'd0, b), 1'b1, 1'b1, (b >> s) | fill, "sra");
            execute(special(FN_SLLV, 5'd0, rs, b), 1'b1, 1'b1, b << s, "sllv");
            execute(special(FN_SRLV, 5'd0, rs, b), 1'b1, 1'b1, b >> s, "srlv");
            execute(special(FN_SRAV, 5'd0, rs, b), 1'b1, 1'b1, (b >> s) | fill, "srav");
        end
    endtask

    task automatic moveTest();
        logic [31:0] a;
        logic [31:0] b;
        a = randWord();
        b = randWord() | 32'h1;  // Forced nonzero
        execute(special(FN_MOVN, 5'd0, a, b), 1'b1, 1'b1, a, "movn taken");
        execute(special(FN_MOVZ, 5'd0, a, b), 1'b0, 1'b0, 32'd0, "movz skipped");
        execute(special(FN_MOVN, 5'd0, a, 32'd0), 1'b0, 1'b0, 32'd0, "movn skipped");
        execute(special(FN_MOVZ, 5'd0, a, 32'd0), 1'b1, 1'b1, a, "movz taken");
    endtask

    task automatic multiplyTest();
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] prod;
        for (int i = 0; i < 4; i++) begin
            a    = randWord();
            b    = randWord();
            prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // Wraps to signed 64-bit product
            modelHiLo = prod;
            execute(special(FN_MULT, 5'd0, a, b), 1'b0, 1'b0, 32'd0, "mult");
            readHiLo("hilo after mult");
            modelHiLo = {32'd0, a} * {32'd0, b};
            execute(special(FN_MULTU, 5'd0, a, b), 1'b0, 1'b0, 32'd0, "multu");
            readHiLo("hilo after multu");
            // Two madds in a row accumulate
            modelHiLo = modelHiLo + prod + prod;
            execute(encode(OP_SPECIAL2, FN_MADD, 5'd0, a, b), 1'b0, 1'b0, 32'd0, "madd");
            execute(encode(OP_SPECIAL2, FN_MADD, 5'd0, a, b), 1'b0, 1'b0, 32'd0, "madd");
            readHiLo("hilo after madd");
            modelHiLo = modelHiLo - prod;
            execute(encode(OP_SPECIAL2, FN_MSUB, 5'd0, a, b), 1'b0, 1'b0, 32'd0, "msub");
            readHiLo("hilo after msub");
            execute(encode(OP_SPECIAL2, FN_MUL, 5'd0, a, b), 1'b1, 1'b1, a * b, "mul");
            readHiLo("hilo after mul");
        end
    endtask

    task automatic extendUndefTest();
        logic [31:0] b;
        for (int i = 0; i < 4; i++) begin
            b = randWord();
            b[7]  = i[0];
            b[15] = i[1];
            execute(encode(OP_SPECIAL3, FN_BSHFL, SA_SEB, 32'd0, b), 1'b1, 1'b1,
                    b[7] ? (b | 32'hffff_ff00) : (b & 32'h0000_00ff), "seb");
            execute(encode(OP_SPECIAL3, FN_BSHFL, SA_SEH, 32'd0, b), 1'b1, 1'b1,
                    b[15] ? (b | 32'hffff_0000) : (b & 32'h0000_ffff), "seh");
        end
        // Reserved encodings fall through to no write
        execute(special(6'h01, 5'd0, randWord(), randWord()), 1'b0, 1'b1, 32'd0, "funct 01");
        execute(special(6'h3f, 5'd0, randWord(), randWord()), 1'b0, 1'b1, 32'd0, "funct 3f");
        execute(encode(6'h08, 6'h20, 5'd0, randWord(), randWord()), 1'b0, 1'b1, 32'd0, "addi");
        execute(encode(OP_SPECIAL3, FN_BSHFL, 5'h02, 32'd0, randWord()), 1'b0, 1'b1, 32'd0,
                "wsbh");
        execute(encode(OP_SPECIAL2, 6'h3f, 5'd0, randWord(), randWord()), 1'b0, 1'b1, 32'd0,
                "special2 3f");
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        reset     = 1'b1;
        issue     = 1'b1;  // A mult held through reset must leave no trace
        instr     = encode(OP_SPECIAL, FN_MULT, 5'd0, 32'h1234_5678, 32'h9abc_def0);
        modelHiLo = 64'd0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        issue = 1'b0;
        instr = '0;
        resetTest();
        arithLogicTest();
        shiftTest();
        moveTest();
        multiplyTest();
        extendUndefTest();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sources.f
logic/mipsAluPkg.sv
logic/aluControl.sv
logic/alu32Bit.sv
logic/executeRegisters.sv
logic/executeStage.sv
test/executeStage_chk.sv
test/executeStageTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the execute stage regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module executeStageTb -Mdir obj_dir -o executeStageSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/executeStageSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
